// File: Bender.yml
package:
  name: cam_cfg

sources:
  - files:
      - cam_cfg_pkg.sv
      - cam_reg_table.sv
      - cam_cfg_seq.sv
      - cam_cfg_top.sv
  - target: simulation
    files:
      - tb_cam_cfg_top.sv

// File: all.f
cam_cfg_pkg.sv
cam_reg_table.sv
cam_cfg_seq.sv
cam_cfg_top.sv
tb_cam_cfg_top.sv

// File: cam_cfg_pkg.sv
/*
 * OV5640 configuration package
 * Widths, sensor power-up timing and the output resolution
 * shared by the register sequencer and its lookup table.
 */

`default_nettype none

package cam_cfg_pkg;

    // ----------------------------------------
    // Widths
    // ----------------------------------------
    typedef logic [15:0] reg_addr_t;   // Sensor register address
    typedef logic [7:0]  reg_data_t;   // Register value
    typedef logic [23:0] cfg_word_t;   // {addr, value} for one SCCB write
    typedef logic [7:0]  reg_idx_t;    // Position in the write list
    typedef logic [12:0] frame_dim_t;  // Pixels or lines
    typedef logic [14:0] pwr_cnt_t;    // Power-up wait counter

    // ----------------------------------------
    // Sequencer timing
    // ----------------------------------------

    // Sensor needs 20 ms after power-up before the first SCCB access.
    // The configuration clock runs at 1 MHz, so one cycle is 1 us.
    localparam pwr_cnt_t POWER_UP_CYCLES = 15'd20000;

    // Entries in the write list
    localparam reg_idx_t REG_NUM = 8'd40;

    // ----------------------------------------
    // Resolution and frame timing
    // ----------------------------------------
    localparam frame_dim_t CMOS_H_PIXEL = 13'd1024;  // Active pixels per line
    localparam frame_dim_t CMOS_V_PIXEL = 13'd768;   // Active lines per frame

    localparam frame_dim_t H_BLANK = 13'd1216;
    localparam frame_dim_t V_BLANK = 13'd504;

    // Total line length and frame height as programmed into 380c..380f
    localparam frame_dim_t TOTAL_H_PIXEL = CMOS_H_PIXEL + H_BLANK;
    localparam frame_dim_t TOTAL_V_PIXEL = CMOS_V_PIXEL + V_BLANK;

    // ----------------------------------------
    // Table fill
    // ----------------------------------------

    // Chip-ID high byte is read-only, so writing it is harmless.
    // Used for any index past the end of the list.
    localparam reg_addr_t ID_REG_ADDR = 16'h300A;

endpackage

`default_nettype wire

// File: cam_cfg_seq.sv
/*
 * OV5640 configuration sequencer
 * Waits out the sensor power-up time, then walks the write
 * list one SCCB transfer at a time. Each write starts with an
 * i2c_exec pulse and ends with i2c_done from the master.
 */

`timescale 1ns/1ps
`default_nettype none

module cam_cfg_seq (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 i2c_done,
    output logic                 i2c_exec,
    output cam_cfg_pkg::reg_idx_t reg_idx,
    output logic                 init_done
);

    import cam_cfg_pkg::*;

    pwr_cnt_t pwr_cnt;   // Power-up wait, saturates
    logic     pwr_fire;  // Last cycle of the wait
    logic     more_regs; // Writes still left to start

    assign pwr_fire  = (pwr_cnt == pwr_cnt_t'(POWER_UP_CYCLES - 15'd1));
    assign more_regs = (reg_idx < REG_NUM);

    // ----------------------------------------
    // Power-up delay
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pwr_cnt <= '0;
        end else if (pwr_cnt < POWER_UP_CYCLES) begin
            pwr_cnt <= pwr_cnt + 15'd1;  // Stops at the limit, fires once
        end
    end

    // ----------------------------------------
    // Write issue
    // ----------------------------------------

    // Index counts started writes, so it also reads as the list position
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            reg_idx <= '0;
        end else if (i2c_exec) begin
            reg_idx <= reg_idx + 8'd1;
        end
    end

    // First write after the delay, then one per completed write
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            i2c_exec <= 1'b0;
        end else if (pwr_fire) begin
            i2c_exec <= 1'b1;
        end else if (i2c_done && more_regs) begin
            i2c_exec <= 1'b1;
        end else begin
            i2c_exec <= 1'b0;
        end
    end

    // ----------------------------------------
    // Completion
    // ----------------------------------------

    // Done of the last write, sticky until reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            init_done <= 1'b0;
        end else if (i2c_done && (reg_idx == REG_NUM)) begin
            init_done <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: cam_cfg_top.sv
/*
 * OV5640 power-up configuration
 * Sequencer plus register table. Drives an external SCCB
 * master with exec/done pulses and a 24-bit write word.
 */

`timescale 1ns/1ps
`default_nettype none

module cam_cfg_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  i2c_done,
    output logic                  i2c_exec,
    output cam_cfg_pkg::cfg_word_t lut_data,
    output logic                  init_done
);

    import cam_cfg_pkg::*;

    reg_idx_t reg_idx;  // Current write position

    cam_cfg_seq u_seq (
        .clk       (clk),
        .rst_n     (rst_n),
        .i2c_done  (i2c_done),
        .i2c_exec  (i2c_exec),
        .reg_idx   (reg_idx),
        .init_done (init_done)
    );

    // Word follows the index one cycle later
    cam_reg_table u_table (
        .clk      (clk),
        .rst_n    (rst_n),
        .reg_idx  (reg_idx),
        .lut_data (lut_data)
    );

endmodule

`default_nettype wire

// File: cam_reg_table.sv
/*
 * OV5640 register table
 * Maps a write index to its {address, value} word for an
 * RGB565 DVP setup. Output is registered, one cycle behind
 * the index. Unknown indices return a write to the chip-ID
 * register so nothing real is touched.
 */

`timescale 1ns/1ps
`default_nettype none

module cam_reg_table (
    input  logic                  clk,
    input  logic                  rst_n,
    input  cam_cfg_pkg::reg_idx_t  reg_idx,
    output cam_cfg_pkg::cfg_word_t lut_data
);

    import cam_cfg_pkg::*;

    function automatic cfg_word_t lut_word(input reg_idx_t idx);
        case (idx)
            // ----------------------------------------
            // Soft reset, pads and PLL source
            // ----------------------------------------
            8'd0  : lut_word = {16'h3008, 8'h82};  // Soft reset, power down
            8'd1  : lut_word = {16'h3008, 8'h02};  // Back to normal operation
            8'd2  : lut_word = {16'h3103, 8'h02};  // Clock from PLL
            8'd3  : lut_word = {16'h3017, 8'hff};  // FREX/VSYNC/HREF/PCLK/D[9:6] out
            8'd4  : lut_word = {16'h3018, 8'hff};  // D[5:0], GPIO out
            8'd5  : lut_word = {16'h3037, 8'h13};  // PLL pre-divider
            8'd6  : lut_word = {16'h3108, 8'h01};  // Root divider

            // ----------------------------------------
            // Output format and ISP
            // ----------------------------------------
            8'd7  : lut_word = {16'h3000, 8'h00};  // Release block resets
            8'd8  : lut_word = {16'h3004, 8'hff};  // Enable all clocks
            8'd9  : lut_word = {16'h4300, 8'h61};  // RGB565
            8'd10 : lut_word = {16'h501f, 8'h01};  // ISP RGB path
            8'd11 : lut_word = {16'h440e, 8'h00};
            8'd12 : lut_word = {16'h5000, 8'ha7};  // ISP control

            // ----------------------------------------
            // System clock, 24 MHz in, PCLK 48 MHz
            // ----------------------------------------
            8'd13 : lut_word = {16'h3035, 8'h11};  // System clock divider
            8'd14 : lut_word = {16'h3036, 8'h3c};  // PLL multiplier

            // ----------------------------------------
            // Sensor window timing
            // ----------------------------------------
            8'd15 : lut_word = {16'h3820, 8'h46};  // Vertical flip, binning
            8'd16 : lut_word = {16'h3821, 8'h01};  // Horizontal binning
            8'd17 : lut_word = {16'h3814, 8'h31};  // X subsample
            8'd18 : lut_word = {16'h3815, 8'h31};  // Y subsample
            8'd19 : lut_word = {16'h3800, 8'h00};  // X start high
            8'd20 : lut_word = {16'h3801, 8'h00};  // X start low
            8'd21 : lut_word = {16'h3802, 8'h00};  // Y start high
            8'd22 : lut_word = {16'h3803, 8'h04};  // Y start low
            8'd23 : lut_word = {16'h3804, 8'h0a};  // X end high
            8'd24 : lut_word = {16'h3805, 8'h3f};  // X end low
            8'd25 : lut_word = {16'h3806, 8'h07};  // Y end high
            8'd26 : lut_word = {16'h3807, 8'h9b};  // Y end low

            // ----------------------------------------
            // Output size and total frame size
            // ----------------------------------------

            // DVP output width, 4 + 8 bits
            8'd27 : lut_word = {16'h3808, {4'd0, CMOS_H_PIXEL[11:8]}};
            8'd28 : lut_word = {16'h3809, CMOS_H_PIXEL[7:0]};

            // DVP output height, 3 + 8 bits
            8'd29 : lut_word = {16'h380a, {5'd0, CMOS_V_PIXEL[10:8]}};
            8'd30 : lut_word = {16'h380b, CMOS_V_PIXEL[7:0]};

            // Total line length, 5 + 8 bits
            8'd31 : lut_word = {16'h380c, {3'd0, TOTAL_H_PIXEL[12:8]}};
            8'd32 : lut_word = {16'h380d, TOTAL_H_PIXEL[7:0]};

            // Total frame height
            8'd33 : lut_word = {16'h380e, {3'd0, TOTAL_V_PIXEL[12:8]}};
            8'd34 : lut_word = {16'h380f, TOTAL_V_PIXEL[7:0]};

            // ----------------------------------------
            // DVP clock, ISP, test pattern
            // ----------------------------------------
            8'd35 : lut_word = {16'h3813, 8'h06};  // Y offset
            8'd36 : lut_word = {16'h4837, 8'h22};  // DVP PCLK period
            8'd37 : lut_word = {16'h3824, 8'h02};  // DVP PCLK divider
            8'd38 : lut_word = {16'h5001, 8'ha3};  // ISP control 1
            8'd39 : lut_word = {16'h503d, 8'h00};  // Colour bar off, 8'h80 turns it on

            // Past the list, rewrite the read-only ID register
            default: lut_word = {ID_REG_ADDR, 8'h00};
        endcase
    endfunction

    // Registered lookup
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lut_data <= lut_word('0);  // Entry 0 ready before the first exec
        end else begin
            lut_data <= lut_word(reg_idx);
        end
    end

endmodule

`default_nettype wire

// File: tb_cam_cfg_top.sv
/*
 * Testbench for the OV5640 power-up configuration
 * Models the SCCB master with random done delays, rebuilds
 * the expected write list and checks timing of exec, done
 * and init_done, including resets during the sequence.
 */

`timescale 1ns/1ps
`default_nettype none

module tb_cam_cfg_top;

    import cam_cfg_pkg::*;

    localparam int         CLK_HALF = 5;      // 10 ns period
    localparam logic [7:0] SEED     = 8'd86;
    localparam int         LIMIT    = 30000;  // Cycles allowed per wait

    // Expected list, entry 0 in the top bits; size entries filled in later
    localparam logic [40*16-1:0] ADDR_LIST = {
        16'h3008, 16'h3008, 16'h3103, 16'h3017, 16'h3018, 16'h3037, 16'h3108, 16'h3000,
        16'h3004, 16'h4300, 16'h501f, 16'h440e, 16'h5000, 16'h3035, 16'h3036, 16'h3820,
        16'h3821, 16'h3814, 16'h3815, 16'h3800, 16'h3801, 16'h3802, 16'h3803, 16'h3804,
        16'h3805, 16'h3806, 16'h3807, 16'h3808, 16'h3809, 16'h380a, 16'h380b, 16'h380c,
        16'h380d, 16'h380e, 16'h380f, 16'h3813, 16'h4837, 16'h3824, 16'h5001, 16'h503d};
    localparam logic [40*8-1:0] VAL_LIST = {
        8'h82, 8'h02, 8'h02, 8'hff, 8'hff, 8'h13, 8'h01, 8'h00,
        8'hff, 8'h61, 8'h01, 8'h00, 8'ha7, 8'h11, 8'h3c, 8'h46,
        8'h01, 8'h31, 8'h31, 8'h00, 8'h00, 8'h00, 8'h04, 8'h0a,
        8'h3f, 8'h07, 8'h9b, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00,
        8'h00, 8'h00, 8'h00, 8'h06, 8'h22, 8'h02, 8'ha3, 8'h00};

    logic      clk;
    logic      rst_n;
    logic      i2c_done;
    logic      i2c_exec;
    cfg_word_t lut_data;
    logic      init_done;

    logic [7:0] lfsr;
    int         checks = 0;
    int         errors = 0;
    int         cyc = 0;          // Edges since reset release
    int         done_cyc = -10;   // Cycle of the latest i2c_done
    int         rst_gen = 0;
    reg_idx_t   n_exec = '0;      // Writes started since reset
    logic       outstanding = 1'b0;
    logic       init_seen = 1'b0;
    logic       timed_out = 1'b0;
    string      timeout_what = "";

    cam_cfg_top u_cam_cfg_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .i2c_done  (i2c_done),
        .i2c_exec  (i2c_exec),
        .lut_data  (lut_data),
        .init_done (init_done)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    // ----------------------------------------
    // Reference and random source
    // ----------------------------------------
    function automatic cfg_word_t exp_word(input reg_idx_t idx);
        int         pos;
        reg_addr_t  addr;
        reg_data_t  val;
        frame_dim_t dim;
        frame_dim_t hi;
        if (idx >= REG_NUM) return {ID_REG_ADDR, 8'h00};
        pos  = int'(REG_NUM) - 1 - int'(idx);
        addr = ADDR_LIST[pos*16 +: 16];
        val  = VAL_LIST[pos*8 +: 8];
        if (idx >= 8'd27 && idx <= 8'd34) begin
            case (int'(idx - 8'd27) / 2)
                0:       dim = CMOS_H_PIXEL;
                1:       dim = CMOS_V_PIXEL;
                2:       dim = TOTAL_H_PIXEL;
                default: dim = TOTAL_V_PIXEL;
            endcase
            hi  = dim >> 8;
            val = idx[0] ? hi[7:0] : dim[7:0];  // Odd index holds the high byte
        end
        return {addr, val};
    endfunction

    function automatic logic [7:0] lfsr_next(input logic [7:0] s);
        return s[0] ? ((s >> 1) ^ 8'hB8) : (s >> 1);
    endfunction

    function automatic logic [7:0] rand_bits(input int n);
        logic [7:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[6:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
        return v;
    endfunction

    // ----------------------------------------
    // Compare tasks
    // ----------------------------------------
    task automatic check_word(input string name, input cfg_word_t got, input cfg_word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input reg_idx_t got, input reg_idx_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    // ----------------------------------------
    // SCCB master model
    // ----------------------------------------
    task automatic answer_write();
        int gen;
        int delay;
        gen   = rst_gen;
        delay = 2 + int'(rand_bits(3));  // 2 to 9 cycles
        repeat (delay) @(posedge clk);
        #1;
        if (gen == rst_gen && rst_n) begin  // Dropped if a reset came in between
            i2c_done = 1'b1;
            @(posedge clk);
            #1 i2c_done = 1'b0;
        end
    endtask

    always @(negedge rst_n) rst_gen++;

    always @(negedge clk) begin
        if (rst_n && i2c_exec) answer_write();
    end

    // ----------------------------------------
    // Monitor
    // ----------------------------------------
    always @(posedge clk) begin
        if (!rst_n) cyc <= 0;
        else        cyc <= cyc + 1;
    end

    always @(negedge clk) begin
        if (!rst_n) begin
            check_bit("i2c_exec", i2c_exec, 1'b0);
            check_bit("init_done", init_done, 1'b0);
            n_exec      = '0;
            outstanding = 1'b0;
            init_seen   = 1'b0;
            done_cyc    = -10;
        end else begin
            if (n_exec == 0 && cyc <= int'(POWER_UP_CYCLES))
                check_bit("i2c_exec", i2c_exec, cyc == int'(POWER_UP_CYCLES));
            if (i2c_exec) begin
                check_bit("outstanding", outstanding, 1'b0);
                if (n_exec != 0) check_bit("exec_after_done", cyc == done_cyc + 1, 1'b1);
                check_word("lut_data", lut_data, exp_word(n_exec));
                outstanding = 1'b1;
                n_exec++;
            end
            if (i2c_done) begin
                outstanding = 1'b0;
                done_cyc    = cyc;
            end
            if (init_done && !init_seen) begin
                check_bit("init_done_rise", cyc == done_cyc + 1, 1'b1);
                check_count("writes_at_init_done", n_exec, REG_NUM);
                init_seen = 1'b1;
            end else if (init_seen) begin
                check_bit("init_done", init_done, 1'b1);  // Sticky
            end
        end
    end

    // ----------------------------------------
    // Sequencing helpers
    // ----------------------------------------

    // Ends the run once any wait has run out
    initial begin
        wait (timed_out);
        $display("Timeout while waiting for %s", timeout_what);
        $display("Simulation failed");
        $finish;
    end

    task automatic raise_timeout(input string what);
        timeout_what = what;
        timed_out    = 1'b1;
        forever @(posedge clk);  // Held here until the watchdog ends the run
    endtask

    task automatic wait_init_done();
        int n;
        n = 0;
        while (!init_done && n < LIMIT) begin
            @(posedge clk);
            #1 n++;
        end
        if (!init_done) raise_timeout("init_done");
    endtask

    // Returns in the cycle in which write number count is being started
    task automatic wait_exec_start(input reg_idx_t count);
        int n;
        n = 0;
        while (!(i2c_exec && n_exec == count - 8'd1) && n < LIMIT) begin
            @(posedge clk);
            #1 n++;
        end
        if (!(i2c_exec && n_exec == count - 8'd1)) raise_timeout("write exec");
    endtask

    task automatic reset_dut();
        rst_n = 1'b0;  // Called 1 ns after an edge
        repeat (5) @(posedge clk);
        #1 rst_n = 1'b1;
    endtask

    task automatic pulse_done();
        @(posedge clk);
        #1 i2c_done = 1'b1;
        @(posedge clk);
        #1 i2c_done = 1'b0;
        repeat (3) @(posedge clk);
        #1;
    endtask

    task automatic report_test(input string name, input int mark);
        if (errors == mark) $display("Test %s: ok", name);
        else                $display("Test %s: %0d errors", name, errors - mark);
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin
        int mark;
        rst_n    = 1'b0;
        i2c_done = 1'b0;
        lfsr     = SEED;
        mark     = errors;
        reset_dut();
        wait_init_done();
        check_count("write_count", n_exec, REG_NUM);
        report_test("power-up wait and full write list", mark);

        mark = errors;
        repeat (3) pulse_done();  // Stray dones after the list
        repeat (10) @(posedge clk);
        #1;
        check_count("write_count", n_exec, REG_NUM);
        check_bit("init_done", init_done, 1'b1);
        check_word("lut_data", lut_data, exp_word(REG_NUM));  // Index past the list
        report_test("extra done after init_done", mark);

        mark = errors;
        reset_dut();  // Clears init_done, restarts the wait
        wait_exec_start(8'd12);
        report_test("reset after completion", mark);

        mark = errors;
        reset_dut();  // Lands while the exec of write 12 is high
        wait_init_done();
        check_count("write_count", n_exec, REG_NUM);
        report_test("reset mid-sequence and restart", mark);

        $display("Finished, %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
